// ==== src/cpu_pkg.sv ====
package cpu_pkg;

  // ram geometry, shared by the core, the page unit and the memory
  localparam int ADDR_W = 10;  // 1024 words
  localparam int DATA_W = 16;

  typedef logic [ADDR_W-1:0] addr_t;  // logical or physical word address
  typedef logic [DATA_W-1:0] word_t;  // ram word, register value, operand

  // register field of word 0, low bits pick the register
  typedef logic [7:0] reg_num_t;

  // opcode in the upper byte of word 0
  // codes not listed here run as a nop
  typedef enum logic [7:0] {
    JMP       = 8'd1,   // pc <= operand address
    RAM2REG   = 8'd2,   // reg <= ram[operand address]
    REG2RAM   = 8'd3,   // ram[operand address] <= reg
    NUM2REG   = 8'd4,   // reg <= operand
    REG_PLUS  = 8'd5,   // reg <= reg + operand
    REG_MINUS = 8'd6,   // reg <= reg - operand
    EXIT      = 8'd17   // stop the process
  } opcode_t;

endpackage

// ==== src/dual_port_ram.sv ====
module dual_port_ram
  import cpu_pkg::*;
(
  input  logic  clka,
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  word_t wr_data,
  input  addr_t rd_addr,
  output word_t rd_data
);

  word_t mem [2**ADDR_W];  // inferred block ram

  always_ff @(posedge clka) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, returns old data on a same-address write
  always_ff @(posedge clka) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== src/page_mmu.sv ====
module page_mmu
  import cpu_pkg::*;
#(
  parameter int PAGE_BITS = 6
) (
  input  logic  clka,
  input  logic  rst_n,
  input  logic  xlat_req,
  input  addr_t xlat_addr,
  output logic  xlat_done,
  output addr_t xlat_phys
);

  localparam int LP_W      = ADDR_W - PAGE_BITS;  // page number bits
  localparam int NUM_PAGES = 1 << LP_W;

  typedef logic [LP_W-1:0] page_t;

  typedef enum logic [1:0] {
    M_IDLE,
    M_WALK,
    M_ALLOC
  } mmu_state_t;

  mmu_state_t state;

  page_t next_tab [NUM_PAGES];  // next physical page in the chain, tail points to itself
  page_t tag_tab  [NUM_PAGES];  // logical page held by each physical page

  logic [LP_W:0] alloc_cnt;  // next free page, top bit flags exhaustion
  page_t cache_lpage;  // last translated logical page
  page_t cache_ppage;  // and where it lives
  page_t cur_page;  // walk pointer

  page_t req_lpage;
  logic [PAGE_BITS-1:0] req_off;

  page_t in_lpage;
  page_t new_page;

  assign in_lpage = xlat_addr[ADDR_W-1:PAGE_BITS];
  assign new_page = alloc_cnt[LP_W-1:0];

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      state       <= M_IDLE;
      xlat_done   <= 1'b0;
      alloc_cnt   <= (LP_W+1)'(1);
      cache_lpage <= '0;  // logical page 0 sits in physical page 0
      cache_ppage <= '0;
      cur_page    <= '0;
      for (int i = 0; i < NUM_PAGES; i++) begin
        next_tab[i] <= '0;
        tag_tab[i]  <= '0;
      end
    end else begin
      xlat_done <= 1'b0;
      case (state)
        M_IDLE: begin
          if (xlat_req) begin
            if (in_lpage == cache_lpage) begin
              xlat_done <= 1'b1;  // cache hit
            end else begin
              cur_page <= '0;  // chain always starts at page 0
              state    <= M_WALK;
            end
          end
        end
        M_WALK: begin
          if (tag_tab[cur_page] == req_lpage) begin
            xlat_done   <= 1'b1;
            cache_lpage <= req_lpage;
            cache_ppage <= cur_page;
            state       <= M_IDLE;
          end else if (next_tab[cur_page] == cur_page) begin
            state <= M_ALLOC;  // hit the tail, logical page is new
          end else begin
            cur_page <= next_tab[cur_page];
          end
        end
        M_ALLOC: begin
          // link the fresh page after the tail and make it the new tail
          next_tab[cur_page] <= new_page;
          next_tab[new_page] <= new_page;
          tag_tab[new_page]  <= req_lpage;
          alloc_cnt   <= alloc_cnt + 1'b1;
          cache_lpage <= req_lpage;
          cache_ppage <= new_page;
          xlat_done   <= 1'b1;
          state       <= M_IDLE;
        end
        default: state <= M_IDLE;
      endcase
    end
  end

  // request fields and the translated address, only sampled with xlat_done
  always_ff @(posedge clka) begin
    case (state)
      M_IDLE: begin
        if (xlat_req) begin
          req_lpage <= in_lpage;
          req_off   <= xlat_addr[PAGE_BITS-1:0];
          xlat_phys <= {cache_ppage, xlat_addr[PAGE_BITS-1:0]};
        end
      end
      M_WALK:  xlat_phys <= {cur_page, req_off};
      M_ALLOC: xlat_phys <= {new_page, req_off};  // offset is never touched
      default: xlat_phys <= xlat_phys;
    endcase
  end

endmodule

// ==== src/cpu_core.sv ====
module cpu_core
  import cpu_pkg::*;
#(
  parameter int PAGE_BITS = 6,
  parameter int NUM_REGS  = 8
) (
  input  logic     clka,
  input  logic     rst_n,
  input  logic     load_en,
  input  addr_t    load_addr,
  input  word_t    load_data,
  input  logic     run,
  output logic     halted,
  output logic     reg_wr,
  output reg_num_t reg_num,
  output word_t    reg_data,
  output logic     mem_wr,
  output addr_t    mem_addr,
  output word_t    mem_data,
  output logic     xlat_req,
  output addr_t    xlat_addr,
  input  logic     xlat_done,
  input  addr_t    xlat_phys,
  output logic     wr_en,
  output addr_t    wr_addr,
  output word_t    wr_data,
  output addr_t    rd_addr,
  input  word_t    rd_data
);

  localparam int RIDX_W = $clog2(NUM_REGS);

  typedef enum logic [3:0] {
    S_IDLE,   // host loads ram
    S_FETCH,  // translate pc
    S_W0,     // wait for word 0 address
    S_R0A,    // ram samples address
    S_R0B,    // word 0 on rd_data
    S_W1,     // wait for word 1 address
    S_R1A,
    S_R1B,    // word 1 on rd_data
    S_DEC,
    S_WOP,    // wait for operand address
    S_LD,     // load read in flight
    S_EXE,
    S_HALT
  } core_state_t;

  core_state_t state;

  word_t   regs [NUM_REGS];
  addr_t   pc;
  addr_t   pc_phys;  // physical address of word 0
  addr_t   op_phys;  // physical operand address
  opcode_t op;
  reg_num_t rnum;
  word_t   operand;

  logic [RIDX_W-1:0] ridx;
  addr_t pc_inc;
  addr_t opnd_addr;
  logic  is_mem_op;
  logic  is_reg_op;
  word_t exe_result;

  assign ridx      = rnum[RIDX_W-1:0];  // field aliases modulo NUM_REGS
  assign pc_inc    = pc + 1'b1;
  assign opnd_addr = operand[ADDR_W-1:0];
  assign is_mem_op = (op == RAM2REG) || (op == REG2RAM);
  assign is_reg_op = (op == NUM2REG) || (op == REG_PLUS) || (op == REG_MINUS) ||
                     (op == RAM2REG);

  always_comb begin
    case (op)
      REG_PLUS:  exe_result = regs[ridx] + operand;  // wraps at 16 bits
      REG_MINUS: exe_result = regs[ridx] - operand;
      RAM2REG:   exe_result = rd_data;
      default:   exe_result = operand;
    endcase
  end

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      pc       <= '0;
      halted   <= 1'b0;
      xlat_req <= 1'b0;
      reg_wr   <= 1'b0;
      mem_wr   <= 1'b0;
      wr_en    <= 1'b0;
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      xlat_req <= 1'b0;
      reg_wr   <= 1'b0;
      mem_wr   <= 1'b0;
      wr_en    <= 1'b0;
      case (state)
        S_IDLE: begin
          wr_en <= load_en && !run;  // host write passes straight to ram
          if (run) begin
            state <= S_FETCH;
          end
        end
        S_FETCH: begin
          xlat_req <= 1'b1;
          state    <= S_W0;
        end
        S_W0:  if (xlat_done) state <= S_R0A;
        S_R0A: state <= S_R0B;
        S_R0B: begin
          // word 1 in the same page needs no page unit trip
          if (pc_inc[PAGE_BITS-1:0] != '0) begin
            state <= S_R1A;
          end else begin
            xlat_req <= 1'b1;
            state    <= S_W1;
          end
        end
        S_W1:  if (xlat_done) state <= S_R1A;
        S_R1A: state <= S_R1B;
        S_R1B: begin
          pc    <= pc + 2'd2;
          state <= S_DEC;
        end
        S_DEC: begin
          if (is_mem_op) begin
            xlat_req <= 1'b1;
            state    <= S_WOP;
          end else begin
            state <= S_EXE;
          end
        end
        S_WOP: begin
          if (xlat_done) begin
            state <= (op == RAM2REG) ? S_LD : S_EXE;
          end
        end
        S_LD: state <= S_EXE;
        S_EXE: begin
          state <= S_FETCH;
          if (is_reg_op) begin
            regs[ridx] <= exe_result;
            reg_wr     <= 1'b1;
          end
          case (op)
            JMP: pc <= opnd_addr;
            REG2RAM: begin
              wr_en  <= 1'b1;
              mem_wr <= 1'b1;
            end
            EXIT: begin
              halted <= 1'b1;
              state  <= S_HALT;
            end
            default: ;  // nop or register op handled above
          endcase
        end
        S_HALT: state <= S_HALT;  // only reset leaves
        default: state <= S_IDLE;
      endcase
    end
  end

  // addresses, instruction fields and event payloads
  always_ff @(posedge clka) begin
    case (state)
      S_IDLE: begin
        wr_addr <= load_addr;
        wr_data <= load_data;
      end
      S_FETCH: xlat_addr <= pc;
      S_W0: begin
        if (xlat_done) begin
          rd_addr <= xlat_phys;
          pc_phys <= xlat_phys;
        end
      end
      S_R0B: begin
        op        <= opcode_t'(rd_data[15:8]);
        rnum      <= rd_data[7:0];
        xlat_addr <= pc_inc;
        rd_addr   <= pc_phys + 1'b1;  // replaced if word 1 crosses a page
      end
      S_W1:  if (xlat_done) rd_addr <= xlat_phys;
      S_R1B: operand <= rd_data;
      S_DEC: xlat_addr <= opnd_addr;
      S_WOP: begin
        if (xlat_done) begin
          op_phys <= xlat_phys;
          rd_addr <= xlat_phys;
        end
      end
      S_EXE: begin
        reg_num  <= reg_num_t'(ridx);
        reg_data <= exe_result;
        mem_addr <= op_phys;
        mem_data <= regs[ridx];
        wr_addr  <= op_phys;
        wr_data  <= regs[ridx];
      end
      default: rd_addr <= rd_addr;
    endcase
  end

endmodule

// ==== src/cpu_top.sv ====
module cpu_top
  import cpu_pkg::*;
#(
  parameter int PAGE_BITS = 6,
  parameter int NUM_REGS  = 8
) (
  input  logic     clka,
  input  logic     rst_n,
  input  logic     load_en,
  input  addr_t    load_addr,
  input  word_t    load_data,
  input  logic     run,
  output logic     halted,
  output logic     reg_wr,
  output reg_num_t reg_num,
  output word_t    reg_data,
  output logic     mem_wr,
  output addr_t    mem_addr,
  output word_t    mem_data
);

  logic  xlat_req;
  addr_t xlat_addr;
  logic  xlat_done;
  addr_t xlat_phys;
  logic  wr_en;
  addr_t wr_addr;
  word_t wr_data;
  addr_t rd_addr;
  word_t rd_data;

  cpu_core #(
    .PAGE_BITS(PAGE_BITS),
    .NUM_REGS (NUM_REGS)
  ) u_core (
    .clka     (clka),
    .rst_n    (rst_n),
    .load_en  (load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .run      (run),
    .halted   (halted),
    .reg_wr   (reg_wr),
    .reg_num  (reg_num),
    .reg_data (reg_data),
    .mem_wr   (mem_wr),
    .mem_addr (mem_addr),
    .mem_data (mem_data),
    .xlat_req (xlat_req),
    .xlat_addr(xlat_addr),
    .xlat_done(xlat_done),
    .xlat_phys(xlat_phys),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  page_mmu #(
    .PAGE_BITS(PAGE_BITS)
  ) u_mmu (
    .clka     (clka),
    .rst_n    (rst_n),
    .xlat_req (xlat_req),
    .xlat_addr(xlat_addr),
    .xlat_done(xlat_done),
    .xlat_phys(xlat_phys)
  );

  dual_port_ram u_ram (
    .clka   (clka),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

endmodule

// ==== dv/cpu_asserts.sv ====
module cpu_asserts
  import cpu_pkg::*;
#(
  parameter int PAGE_BITS = 6
) (
  input logic                      clka,
  input logic                      rst_n,
  input logic                      xlat_req,
  input logic                      xlat_done,
  input addr_t                     xlat_phys,
  input logic [ADDR_W-PAGE_BITS:0] alloc_cnt
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_PAGES = 2**(ADDR_W - PAGE_BITS);

  logic pending = 1'b0;  // a request is waiting for its done
  int   fail_cnt = 0;

  always @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (xlat_req) begin
      pending <= 1'b1;
    end else if (xlat_done) begin
      pending <= 1'b0;
    end
  end

  done_has_req: assert property (@(posedge clka) disable iff (!rst_n) xlat_done |-> pending)
    else begin
      $error("xlat_done fired with no request outstanding");
      fail_cnt++;
    end

  // page 0 is never handed out, and the counter stops at the page count
  alloc_no_wrap: assert property (@(posedge clka) disable iff (!rst_n)
                                  alloc_cnt != '0 && alloc_cnt <= NUM_PAGES)
    else begin
      $error("allocation counter out of range: %0d", alloc_cnt);
      fail_cnt++;
    end

  phys_in_range: assert property (@(posedge clka) disable iff (!rst_n)
                                  xlat_done |-> int'(xlat_phys) / (2**PAGE_BITS) < int'(alloc_cnt))
    else begin
      $error("translated page %0d not yet allocated", int'(xlat_phys) / (2**PAGE_BITS));
      fail_cnt++;
    end

endmodule

bind page_mmu cpu_asserts #(.PAGE_BITS(PAGE_BITS)) u_asserts (.*);

// ==== dv/cpu_checker.sv ====
module cpu_checker
  import cpu_pkg::*;
#(
  parameter int PAGE_BITS = 6,
  parameter int NUM_REGS  = 8
) (
  input logic     clka,
  input logic     rst_n,
  input logic     load_en,
  input addr_t    load_addr,
  input word_t    load_data,
  input logic     run,
  input logic     halted,
  input logic     reg_wr,
  input reg_num_t reg_num,
  input word_t    reg_data,
  input logic     mem_wr,
  input addr_t    mem_addr,
  input word_t    mem_data
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LP_W = ADDR_W - PAGE_BITS;

  word_t image [2**ADDR_W];  // what the host loaded
  int    page_of [2**LP_W];  // physical page of each logical page, -1 if unmapped
  int    next_free;
  logic  exp_mem [$];  // expected events in order, 1 for a store
  addr_t exp_tag [$];  // register number or physical address
  word_t exp_data [$];
  int    err_cnt = 0;
  int    test_cnt = 0;
  int    event_cnt = 0;
  int    test_err = 0;
  logic  started = 1'b0;
  logic  halt_seen = 1'b0;

  function automatic addr_t translate(addr_t la);
    int lp;
    lp = int'(la) / (2**PAGE_BITS);
    if (page_of[lp] < 0) begin
      page_of[lp] = next_free;  // first touch takes the next page
      next_free++;
    end
    return addr_t'(page_of[lp] * (2**PAGE_BITS) + int'(la) % (2**PAGE_BITS));
  endfunction

  function automatic void push_event(logic is_mem, addr_t tag, word_t data);
    exp_mem.push_back(is_mem);
    exp_tag.push_back(tag);
    exp_data.push_back(data);
  endfunction

  // runs the loaded program and lists the register writes and stores it makes
  function automatic void build_expected();
    word_t mem [2**ADDR_W];
    word_t regs [NUM_REGS];
    addr_t pc;
    addr_t pa;
    word_t w0;
    word_t w1;
    int    r;
    bit    stop;
    mem = image;
    for (int i = 0; i < NUM_REGS; i++) begin
      regs[i] = '0;
    end
    for (int p = 0; p < 2**LP_W; p++) begin
      page_of[p] = -1;
    end
    page_of[0] = 0;
    next_free  = 1;
    pc   = '0;
    stop = 1'b0;
    for (int s = 0; s < 4 * 2**PAGE_BITS && !stop; s++) begin
      w0 = mem[translate(pc)];
      w1 = mem[translate(pc + 1'b1)];
      pc = pc + 2'd2;
      r  = w0[7:0] % NUM_REGS;
      case (w0[15:8])
        JMP:       pc = w1[ADDR_W-1:0];
        RAM2REG: begin
          regs[r] = mem[translate(w1[ADDR_W-1:0])];
          push_event(1'b0, addr_t'(r), regs[r]);
        end
        REG2RAM: begin
          pa      = translate(w1[ADDR_W-1:0]);
          mem[pa] = regs[r];
          push_event(1'b1, pa, regs[r]);
        end
        NUM2REG: begin
          regs[r] = w1;
          push_event(1'b0, addr_t'(r), regs[r]);
        end
        REG_PLUS: begin
          regs[r] = regs[r] + w1;
          push_event(1'b0, addr_t'(r), regs[r]);
        end
        REG_MINUS: begin
          regs[r] = regs[r] - w1;
          push_event(1'b0, addr_t'(r), regs[r]);
        end
        EXIT:      stop = 1'b1;
        default:   ;
      endcase
    end
  endfunction

  task automatic check_event(logic is_mem, addr_t tag, word_t data);
    string what;
    what = is_mem ? "store" : "register write";
    event_cnt++;
    if (halt_seen || exp_mem.size() == 0) begin
      $display("unexpected %s %0h = %h at %0t ns", what, tag, data, $time);
      err_cnt++;
      test_err++;
    end else begin
      if (exp_mem[0] != is_mem || exp_tag[0] != tag || exp_data[0] != data) begin
        $display("Mismatch at %0t ns: %s %0h = %h, expected %s %0h = %h", $time, what, tag,
                 data, exp_mem[0] ? "store" : "register write", exp_tag[0], exp_data[0]);
        err_cnt++;
        test_err++;
      end
      void'(exp_mem.pop_front());
      void'(exp_tag.pop_front());
      void'(exp_data.pop_front());
    end
  endtask

  always @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      started   = 1'b0;
      halt_seen = 1'b0;
      test_err  = 0;
      exp_mem.delete();
      exp_tag.delete();
      exp_data.delete();
    end else begin
      if (load_en && !run) begin
        image[load_addr] = load_data;
      end
      if (run && !started) begin
        started = 1'b1;
        build_expected();
      end
      if (reg_wr) begin
        check_event(1'b0, addr_t'(reg_num), reg_data);
      end
      if (mem_wr) begin
        check_event(1'b1, mem_addr, mem_data);
      end
      if (halt_seen && !halted) begin
        $display("test %0d: halted went low again before reset at %0t ns", test_cnt, $time);
        err_cnt++;
        test_err++;
      end
      if (halted && !halt_seen) begin
        halt_seen = 1'b1;
        test_cnt++;
        if (exp_mem.size() != 0) begin
          $display("test %0d halted with %0d expected events missing", test_cnt, exp_mem.size());
          err_cnt++;
          test_err++;
        end
        $display("test %0d done: %0d errors", test_cnt, test_err);
      end
    end
  end

endmodule

// ==== dv/tb_top.sv ====
module tb_top
  import cpu_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PAGE_BITS  = 6;
  localparam int NUM_REGS   = 8;
  localparam int PSIZE      = 2**PAGE_BITS;
  localparam int NUM_TESTS  = 8;
  localparam int PROG_INSTR = 28;  // code ends at word 55, the rest of page 0 holds data
  localparam int MAX_CYCLES = NUM_TESTS * (1040 + 64 * 60);

  logic     clka;
  logic     rst_n;
  logic     load_en;
  addr_t    load_addr;
  word_t    load_data;
  logic     run;
  logic     halted;
  logic     reg_wr;
  reg_num_t reg_num;
  word_t    reg_data;
  logic     mem_wr;
  addr_t    mem_addr;
  word_t    mem_data;
  word_t    prog [PSIZE];
  int       cycles = 0;

  always #5 clka = ~clka;

  cpu_top #(.PAGE_BITS(PAGE_BITS), .NUM_REGS(NUM_REGS)) UUT (.*);

  cpu_checker #(.PAGE_BITS(PAGE_BITS), .NUM_REGS(NUM_REGS)) chk (.*);

  always @(posedge clka) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // data address on logical pages 0..14, on page 0 only above the code
  function automatic addr_t pick_addr();
    int lp;
    lp = $urandom_range(14, 0);
    if (lp == 0) begin
      return addr_t'(2 * PROG_INSTR + $urandom_range(PSIZE - 1 - 2 * PROG_INSTR, 0));
    end
    return addr_t'(lp * PSIZE + $urandom_range(PSIZE - 1, 0));
  endfunction

  task automatic gen_program();
    addr_t used [$];
    addr_t a;
    int    kind;
    for (int i = 0; i < PSIZE; i++) begin
      prog[i] = '0;
    end
    for (int i = 0; i < PROG_INSTR - 1; i++) begin
      kind        = $urandom_range(9, 0);
      prog[2*i]   = {8'h40, 8'($urandom)};  // unlisted opcode, runs as a nop
      prog[2*i+1] = word_t'($urandom);
      case (kind)
        0, 1: prog[2*i][15:8] = NUM2REG;
        2:    prog[2*i][15:8] = REG_PLUS;
        3:    prog[2*i][15:8] = REG_MINUS;
        4, 5: begin
          a = pick_addr();
          used.push_back(a);
          prog[2*i][15:8]         = REG2RAM;
          prog[2*i+1][ADDR_W-1:0] = a;
        end
        6, 7: begin
          if (used.size() > 0 && $urandom_range(1, 0) == 1) begin
            a = used[$urandom_range(used.size() - 1, 0)];  // revisit a stored word
          end else begin
            a = pick_addr();
          end
          prog[2*i][15:8]         = RAM2REG;
          prog[2*i+1][ADDR_W-1:0] = a;
        end
        8: begin
          if (i + 2 < PROG_INSTR) begin
            prog[2*i][15:8]         = JMP;
            prog[2*i+1][ADDR_W-1:0] = addr_t'(2 * (i + 2));  // skip the next instruction
          end
        end
        default: ;
      endcase
    end
    prog[2*PROG_INSTR-2] = {EXIT, 8'h00};
  endtask

  task automatic run_test();
    rst_n   = 1'b0;
    run     = 1'b0;
    load_en = 1'b0;
    repeat (16) @(posedge clka);
    #1 rst_n = 1'b1;
    gen_program();
    for (int a = 0; a < 2**ADDR_W; a++) begin
      load_en   = 1'b1;
      load_addr = addr_t'(a);
      load_data = (a < PSIZE) ? prog[a] : word_t'($urandom);
      @(posedge clka);
      #1;
    end
    load_en = 1'b0;
    run     = 1'b1;
    while (!halted) begin
      @(posedge clka);
      #1;
    end
    repeat (4) @(posedge clka);  // window for stray events after exit
    #1;
  endtask

  initial begin
    clka      = 1'b0;
    rst_n     = 1'b0;
    run       = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    void'($urandom(32'hb12eec48));
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test();
    end
    $display("%0d tests, %0d events, %0d errors, %0d assertion failures", chk.test_cnt,
             chk.event_cnt, chk.err_cnt, UUT.u_mmu.u_asserts.fail_cnt);
    if (chk.err_cnt == 0 && chk.test_cnt == NUM_TESTS && UUT.u_mmu.u_asserts.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
src/cpu_pkg.sv
src/dual_port_ram.sv
src/page_mmu.sv
src/cpu_core.sv
src/cpu_top.sv
dv/cpu_asserts.sv
dv/cpu_checker.sv
dv/tb_top.sv
